/* rtl/div_consts.svh */
// constants for the 64-bit divide unit
// operand and word widths, one-hot op codes, iteration counts

`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// ========================================
// widths
`define DIV_XLEN    64  // operand width
`define DIV_WLEN    32  // word op width
`define DIV_OP_W    8   // one-hot op code width
`define DIV_CNT_W   7   // iteration counter width

// ========================================
// one-hot op codes, bit 7 down to bit 0
`define DIV_OP_DIV    8'b1000_0000  // signed 64
`define DIV_OP_DIVU   8'b0100_0000  // unsigned 64
`define DIV_OP_DIVUW  8'b0010_0000  // unsigned 32
`define DIV_OP_DIVW   8'b0001_0000  // signed 32
`define DIV_OP_REM    8'b0000_1000  // signed 64
`define DIV_OP_REMU   8'b0000_0100  // unsigned 64
`define DIV_OP_REMUW  8'b0000_0010  // unsigned 32
`define DIV_OP_REMW   8'b0000_0001  // signed 32

// ========================================
// loop lengths
`define DIV_ITER_D  64  // doubleword ops
`define DIV_ITER_W  32  // word ops

`endif

/* rtl/div_pkg.sv */
// shared types of the divide unit
// vector typedefs and the stage state enums

`default_nettype none

`include "div_consts.svh"

package div_pkg;

  // ========================================
  // vectors
  typedef logic [`DIV_XLEN-1:0]  xlen_t;      // operand or result
  typedef logic [`DIV_OP_W-1:0]  div_op_t;    // one-hot op code
  typedef logic [`DIV_CNT_W-1:0] iter_cnt_t;  // loop counter

  // ========================================
  // state machines
  typedef enum logic [1:0] {
    PREP_IDLE,       // waiting for a request
    PREP_OFFER,      // req high, waiting for ack
    PREP_WAIT_DROP   // req low, waiting for ack to fall
  } prep_state_t;

  typedef enum logic [2:0] {
    CORE_IDLE,       // waiting for a job
    CORE_LOAD_ACK,   // job loaded, ack high
    CORE_ITER,       // shift-subtract loop
    CORE_OFFER,      // result offered downstream
    CORE_WAIT_DROP   // waiting for ack to fall
  } core_state_t;

  typedef enum logic [1:0] {
    OUT_IDLE,        // waiting for a finished job
    OUT_HOLD,        // result valid to the core pipeline
    OUT_RELEASE      // result taken, closing handshake
  } out_state_t;

endpackage

`default_nettype wire

/* rtl/div_if.sv */
// internal stage interfaces
// div_req_if carries a prepared job into the core
// div_res_if carries a finished job to the output side

`default_nettype none

interface div_req_if
  import div_pkg::*;
();
  logic    req;           // four-phase request
  logic    ack;           // four-phase acknowledge
  div_op_t op;
  xlen_t   dividend_mag;  // word ops arrive left-aligned
  xlen_t   divisor_mag;   // word ops arrive zero-extended
  logic    q_neg;
  logic    r_neg;
  logic    bypass;        // exception or invalid op
  xlen_t   bypass_val;    // final result when bypassed

  modport src (
    output req, op, dividend_mag, divisor_mag, q_neg, r_neg, bypass, bypass_val,
    input  ack
  );

  modport dst (
    input  req, op, dividend_mag, divisor_mag, q_neg, r_neg, bypass, bypass_val,
    output ack
  );
endinterface

interface div_res_if
  import div_pkg::*;
();
  logic    req;
  logic    ack;
  div_op_t op;
  xlen_t   quo_raw;     // unsigned quotient
  xlen_t   rem_raw;     // unsigned remainder
  logic    q_neg;
  logic    r_neg;
  logic    bypass;
  xlen_t   bypass_val;

  modport src (
    output req, op, quo_raw, rem_raw, q_neg, r_neg, bypass, bypass_val,
    input  ack
  );

  modport dst (
    input  req, op, quo_raw, rem_raw, q_neg, r_neg, bypass, bypass_val,
    output ack
  );
endinterface

`default_nettype wire

/* rtl/div_operand_prep.sv */
// input stage of the divide unit
// op decode, sign extension and magnitudes
// divide-by-zero, signed overflow and invalid op detection
// offers the prepared job to the core over div_req_if

`default_nettype none

`include "div_consts.svh"

module div_operand_prep
  import div_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    div_valid_i,
  input  div_op_t div_op_i,
  input  xlen_t   dividend_i,
  input  xlen_t   divisor_i,
  output logic    stall_o,
  div_req_if.src  req
);

  localparam int EXT = `DIV_XLEN - `DIV_WLEN;

  prep_state_t state_q;
  logic        req_q;
  logic        accept;

  logic  op_valid, is_word, is_signed, is_rem;
  xlen_t a_op, b_op;       // operands after word extension
  xlen_t a_sext;           // dividend as seen by the result
  logic  a_neg, b_neg;
  xlen_t a_mag, b_mag;
  logic  div_zero, div_ovf;
  xlen_t exc_val;

  // registered job
  div_op_t op_q;
  xlen_t   dividend_mag_q, divisor_mag_q, bypass_val_q;
  logic    q_neg_q, r_neg_q, bypass_q;

  // ========================================
  // decode
  assign op_valid  = $onehot(div_op_i);
  assign is_word   = |(div_op_i & (`DIV_OP_DIVUW | `DIV_OP_DIVW | `DIV_OP_REMUW | `DIV_OP_REMW));
  assign is_signed = |(div_op_i & (`DIV_OP_DIV | `DIV_OP_DIVW | `DIV_OP_REM | `DIV_OP_REMW));
  assign is_rem    = |(div_op_i & (`DIV_OP_REM | `DIV_OP_REMU | `DIV_OP_REMUW | `DIV_OP_REMW));

  // ========================================
  // operands and magnitudes
  always_comb begin
    a_sext = {{EXT{dividend_i[`DIV_WLEN-1]}}, dividend_i[`DIV_WLEN-1:0]};
    if (is_word) begin
      a_op = is_signed ? a_sext : {{EXT{1'b0}}, dividend_i[`DIV_WLEN-1:0]};
      b_op = is_signed ? {{EXT{divisor_i[`DIV_WLEN-1]}}, divisor_i[`DIV_WLEN-1:0]}
                       : {{EXT{1'b0}}, divisor_i[`DIV_WLEN-1:0]};
    end else begin
      a_op   = dividend_i;
      b_op   = divisor_i;
      a_sext = dividend_i;  // doubleword result uses the full dividend
    end
  end

  assign a_neg = is_signed & a_op[`DIV_XLEN-1];
  assign b_neg = is_signed & b_op[`DIV_XLEN-1];
  assign a_mag = a_neg ? -a_op : a_op;
  assign b_mag = b_neg ? -b_op : b_op;

  // ========================================
  // exceptions
  assign div_zero = is_word ? (divisor_i[`DIV_WLEN-1:0] == '0) : (divisor_i == '0);

  always_comb begin
    if (is_word)
      div_ovf = is_signed
             && dividend_i[`DIV_WLEN-1:0] == {1'b1, {(`DIV_WLEN-1){1'b0}}}
             && &divisor_i[`DIV_WLEN-1:0];
    else
      div_ovf = is_signed
             && dividend_i == {1'b1, {(`DIV_XLEN-1){1'b0}}}
             && &divisor_i;
  end

  always_comb begin
    if (!op_valid)
      exc_val = '0;
    else if (div_zero)
      exc_val = is_rem ? a_sext : '1;   // rem keeps dividend, div gives all ones
    else
      exc_val = is_rem ? '0 : a_sext;   // overflow case
  end

  // ========================================
  // control
  assign accept = (state_q == PREP_IDLE) && div_valid_i;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= PREP_IDLE;
      req_q   <= 1'b0;
    end else begin
      case (state_q)
        PREP_IDLE: if (accept) begin
          req_q   <= 1'b1;
          state_q <= PREP_OFFER;
        end
        PREP_OFFER: if (req.ack) begin
          req_q   <= 1'b0;
          state_q <= PREP_WAIT_DROP;
        end
        PREP_WAIT_DROP: if (!req.ack) state_q <= PREP_IDLE;
        default: state_q <= PREP_IDLE;
      endcase
    end
  end

  // job register, held stable while req is up
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q           <= div_op_i;
      dividend_mag_q <= is_word ? {a_mag[`DIV_WLEN-1:0], {EXT{1'b0}}} : a_mag;
      divisor_mag_q  <= is_word ? {{EXT{1'b0}}, b_mag[`DIV_WLEN-1:0]} : b_mag;
      q_neg_q        <= a_neg ^ b_neg;
      r_neg_q        <= a_neg;                  // remainder follows dividend
      bypass_q       <= !op_valid || div_zero || div_ovf;
      bypass_val_q   <= exc_val;
    end
  end

  assign stall_o          = (state_q == PREP_OFFER);
  assign req.req          = req_q;
  assign req.op           = op_q;
  assign req.dividend_mag = dividend_mag_q;
  assign req.divisor_mag  = divisor_mag_q;
  assign req.q_neg        = q_neg_q;
  assign req.r_neg        = r_neg_q;
  assign req.bypass       = bypass_q;
  assign req.bypass_val   = bypass_val_q;

endmodule

`default_nettype wire

/* rtl/div_restoring_core.sv */
// restoring divider core
// loads a job and runs one quotient bit per cycle
// 64 iterations for doubleword ops, 32 for word ops

`default_nettype none

`include "div_consts.svh"

module div_restoring_core
  import div_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  div_req_if.dst req,
  div_res_if.src res
);

  core_state_t state_q;
  iter_cnt_t   cnt_q;
  logic        ack_q;
  logic        res_req_q;
  logic        load_en;
  logic        word_op;

  // remainder in the upper half, quotient in the lower half
  logic [2*`DIV_XLEN-1:0] rq_q;
  xlen_t                  dvs_q;
  logic [`DIV_XLEN+1:0]   trial;   // shifted upper part minus divisor
  logic [2*`DIV_XLEN-1:0] rq_next;

  div_op_t op_q;
  logic    q_neg_q, r_neg_q, bypass_q;
  xlen_t   bypass_val_q;

  assign load_en = (state_q == CORE_IDLE) && req.req;
  assign word_op = |(req.op & (`DIV_OP_DIVUW | `DIV_OP_DIVW | `DIV_OP_REMUW | `DIV_OP_REMW));

  // ========================================
  // one restoring step
  // bit shifted out of the remainder stays in the trial
  assign trial = {1'b0, rq_q[2*`DIV_XLEN-1:`DIV_XLEN-1]} - {2'b00, dvs_q};

  always_comb begin
    if (!trial[`DIV_XLEN+1])
      rq_next = {trial[`DIV_XLEN-1:0], rq_q[`DIV_XLEN-2:0], 1'b1};  // keep difference
    else
      rq_next = {rq_q[2*`DIV_XLEN-2:0], 1'b0};                       // restore
  end

  // ========================================
  // control
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q   <= CORE_IDLE;
      cnt_q     <= '0;
      ack_q     <= 1'b0;
      res_req_q <= 1'b0;
    end else begin
      case (state_q)
        CORE_IDLE: if (req.req) begin
          ack_q   <= 1'b1;
          cnt_q   <= word_op ? iter_cnt_t'(`DIV_ITER_W) : iter_cnt_t'(`DIV_ITER_D);
          state_q <= CORE_LOAD_ACK;
        end
        CORE_LOAD_ACK: if (!req.req) begin
          ack_q <= 1'b0;
          if (bypass_q) begin
            res_req_q <= 1'b1;   // no loop for exceptions
            state_q   <= CORE_OFFER;
          end else begin
            state_q <= CORE_ITER;
          end
        end
        CORE_ITER: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == iter_cnt_t'(1)) begin
            res_req_q <= 1'b1;
            state_q   <= CORE_OFFER;
          end
        end
        CORE_OFFER: if (res.ack) begin
          res_req_q <= 1'b0;
          state_q   <= CORE_WAIT_DROP;
        end
        CORE_WAIT_DROP: if (!res.ack) state_q <= CORE_IDLE;
        default: state_q <= CORE_IDLE;
      endcase
    end
  end

  // ========================================
  // datapath
  always_ff @(posedge clk) begin
    if (load_en) begin
      rq_q         <= {{`DIV_XLEN{1'b0}}, req.dividend_mag};
      dvs_q        <= req.divisor_mag;
      op_q         <= req.op;
      q_neg_q      <= req.q_neg;
      r_neg_q      <= req.r_neg;
      bypass_q     <= req.bypass;
      bypass_val_q <= req.bypass_val;
    end else if (state_q == CORE_ITER) begin
      rq_q <= rq_next;
    end
  end

  assign req.ack        = ack_q;
  assign res.req        = res_req_q;
  assign res.op         = op_q;
  assign res.quo_raw    = rq_q[`DIV_XLEN-1:0];
  assign res.rem_raw    = rq_q[2*`DIV_XLEN-1:`DIV_XLEN];
  assign res.q_neg      = q_neg_q;
  assign res.r_neg      = r_neg_q;
  assign res.bypass     = bypass_q;
  assign res.bypass_val = bypass_val_q;

endmodule

`default_nettype wire

/* rtl/div_result_select.sv */
// output stage of the divide unit
// sign restore, quotient or remainder select, word sign extension
// holds the result until the consumer takes it

`default_nettype none

`include "div_consts.svh"

module div_result_select
  import div_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  div_res_if.dst res,
  input  logic   result_ready_i,
  output xlen_t  result_o,
  output logic   result_ok_o,
  output logic   busy_clear_o
);

  localparam int EXT = `DIV_XLEN - `DIV_WLEN;

  out_state_t state_q;
  logic       ack_q;
  logic       capture;
  logic       is_word, is_rem;
  xlen_t      quo, rem, sel, final_val;
  xlen_t      result_q;

  assign is_word = |(res.op & (`DIV_OP_DIVUW | `DIV_OP_DIVW | `DIV_OP_REMUW | `DIV_OP_REMW));
  assign is_rem  = |(res.op & (`DIV_OP_REM | `DIV_OP_REMU | `DIV_OP_REMUW | `DIV_OP_REMW));

  // ========================================
  // final value
  assign quo = res.q_neg ? -res.quo_raw : res.quo_raw;
  assign rem = res.r_neg ? -res.rem_raw : res.rem_raw;
  assign sel = is_rem ? rem : quo;

  always_comb begin
    if (res.bypass)
      final_val = res.bypass_val;   // already in final form
    else if (is_word)
      final_val = {{EXT{sel[`DIV_WLEN-1]}}, sel[`DIV_WLEN-1:0]};
    else
      final_val = sel;
  end

  // ========================================
  // handshake
  assign capture = (state_q == OUT_IDLE) && res.req;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= OUT_IDLE;
      ack_q   <= 1'b0;
    end else begin
      case (state_q)
        OUT_IDLE: if (capture) begin
          ack_q   <= 1'b1;
          state_q <= OUT_HOLD;
        end
        OUT_HOLD: if (result_ready_i) state_q <= OUT_RELEASE;
        OUT_RELEASE: if (!res.req) begin
          ack_q   <= 1'b0;   // next job may come in now
          state_q <= OUT_IDLE;
        end
        default: state_q <= OUT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (capture) result_q <= final_val;
  end

  assign res.ack      = ack_q;
  assign busy_clear_o = capture;
  assign result_ok_o  = (state_q == OUT_HOLD);
  assign result_o     = result_ok_o ? result_q : '0;  // zero when not valid

endmodule

`default_nettype wire

/* rtl/div_unit.sv */
// top level of the divide unit
// start valid and ready/ok handshake toward the core pipeline
// in-flight flag for the stall output, three stages

`default_nettype none

module div_unit
  import div_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    div_valid_i,
  input  div_op_t div_op_i,
  input  xlen_t   dividend_i,
  input  xlen_t   divisor_i,
  input  logic    result_ready_i,
  output xlen_t   result_o,
  output logic    div_stall_o,
  output logic    result_ok_o
);

  logic busy_q;       // job accepted and not yet at the output
  logic accept;
  logic prep_stall;
  logic busy_clear;

  div_req_if req_bus ();
  div_res_if res_bus ();

  // new work only when nothing is pending toward the pipeline
  assign accept      = div_valid_i && !div_stall_o && !result_ok_o;
  assign div_stall_o = busy_q || prep_stall;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end else if (busy_clear) begin
      busy_q <= 1'b0;
    end
  end

  // ========================================
  // stages
  div_operand_prep u_prep (
    .clk         (clk),
    .rst_n       (rst_n),
    .div_valid_i (accept),
    .div_op_i    (div_op_i),
    .dividend_i  (dividend_i),
    .divisor_i   (divisor_i),
    .stall_o     (prep_stall),
    .req         (req_bus.src)
  );

  div_restoring_core u_core (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req_bus.dst),
    .res   (res_bus.src)
  );

  div_result_select u_select (
    .clk            (clk),
    .rst_n          (rst_n),
    .res            (res_bus.dst),
    .result_ready_i (result_ready_i),
    .result_o       (result_o),
    .result_ok_o    (result_ok_o),
    .busy_clear_o   (busy_clear)
  );

endmodule

`default_nettype wire

/* tb/div_unit_tb.sv */
// testbench for the divide unit
// reference model of the RISC-V divide and remainder rules
// directed, exception, invalid-op and random jobs
// checker with random result back-pressure, error counts, cycle timeout

`default_nettype none

`include "div_consts.svh"

module div_unit_tb;

  localparam int N_RANDOM       = 150;
  localparam int MAX_JOBS       = 200;
  localparam int CYC_PER_JOB    = 80;   // longest job plus hold time
  localparam int TIMEOUT_CYCLES = MAX_JOBS * CYC_PER_JOB;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        div_valid_i;
  logic [7:0]  div_op_i;
  logic [63:0] dividend_i;
  logic [63:0] divisor_i;
  logic        result_ready_i = 1'b0;
  logic [63:0] result_o;
  logic        div_stall_o;
  logic        result_ok_o;

  integer seed = 16;       // stimulus
  integer hold_seed = 16;  // checker hold times
  integer cycles = 0;
  integer jobs_sent = 0;
  integer jobs_checked = 0;
  integer err_value = 0;
  integer err_other = 0;

  // expected results in issue order
  logic [63:0] exp_q[$];
  logic [7:0]  exp_op_q[$];
  logic [63:0] exp_a_q[$];
  logic [63:0] exp_b_q[$];

  // checker state
  logic        in_hold = 1'b0;
  logic [63:0] held_val;
  logic [63:0] cur_exp;
  logic [7:0]  cur_op;
  logic [63:0] cur_a;
  logic [63:0] cur_b;
  logic [2:0]  hold_cnt;
  integer      hold_rnd;

  always #10 clk = ~clk;

  div_unit dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_op_i       (div_op_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .result_ready_i (result_ready_i),
    .result_o       (result_o),
    .div_stall_o    (div_stall_o),
    .result_ok_o    (result_ok_o)
  );

  // ========================================
  // reference model
  function automatic logic [63:0] sext32(input logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  function automatic logic [63:0] div_model(input logic [7:0]  op,
                                            input logic [63:0] a,
                                            input logic [63:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    logic        [31:0] ua;
    logic        [31:0] ub;
    logic signed [63:0] qd;
    logic signed [63:0] rd;
    logic signed [31:0] qw;
    logic signed [31:0] rw;
    logic               ovf_d;
    logic               ovf_w;
    logic        [63:0] r;
    sa    = a;
    sb    = b;
    wa    = a[31:0];
    wb    = b[31:0];
    ua    = a[31:0];
    ub    = b[31:0];
    ovf_d = (a == 64'h8000_0000_0000_0000) && (b == 64'hFFFF_FFFF_FFFF_FFFF);
    ovf_w = (ua == 32'h8000_0000) && (ub == 32'hFFFF_FFFF);
    qd    = '0;
    rd    = '0;
    qw    = '0;
    rw    = '0;
    if (b != 0 && !ovf_d) begin
      qd = sa / sb;  // signed operands only, truncates toward zero
      rd = sa % sb;
    end
    if (ub != 0 && !ovf_w) begin
      qw = wa / wb;
      rw = wa % wb;
    end
    r     = '0;  // invalid codes give zero
    case (op)
      `DIV_OP_DIV:   r = (b == 0) ? '1 : (ovf_d ? a : qd);
      `DIV_OP_DIVU:  r = (b == 0) ? '1 : a / b;
      `DIV_OP_REM:   r = (b == 0) ? a : (ovf_d ? '0 : rd);
      `DIV_OP_REMU:  r = (b == 0) ? a : a % b;
      `DIV_OP_DIVW:  r = (ub == 0) ? '1 : sext32(ovf_w ? ua : qw);
      `DIV_OP_DIVUW: r = (ub == 0) ? '1 : sext32(ua / ub);
      `DIV_OP_REMW:  r = (ub == 0) ? sext32(ua) : sext32(ovf_w ? 32'h0 : rw);
      `DIV_OP_REMUW: r = (ub == 0) ? sext32(ua) : sext32(ua % ub);
      default:       r = '0;
    endcase
    return r;
  endfunction

  // ========================================
  // stimulus tasks
  task automatic send_job(input logic [7:0] op, input logic [63:0] a, input logic [63:0] b);
    @(negedge clk);
    while (div_stall_o || result_ok_o) @(negedge clk);  // unit must be free
    div_valid_i = 1'b1;
    div_op_i    = op;
    dividend_i  = a;
    divisor_i   = b;
    exp_q.push_back(div_model(op, a, b));
    exp_op_q.push_back(op);
    exp_a_q.push_back(a);
    exp_b_q.push_back(b);
    jobs_sent++;
    @(negedge clk);
    div_valid_i = 1'b0;
    assert (div_stall_o === 1'b1) else begin
      $display("FAILED at %0t: div_stall_o expected 1 got %b", $time, div_stall_o);
      err_value++;
    end
  endtask

  task automatic send_all_ops(input logic [63:0] a, input logic [63:0] b);
    integer i;
    for (i = 0; i < 8; i++) begin
      send_job(8'h80 >> i, a, b);  // div down to remw
    end
  endtask

  task automatic send_random_job();
    integer      r;
    logic [7:0]  op;
    logic [63:0] a;
    logic [63:0] b;
    r = $random(seed);
    if (r[7:4] == 4'h0)
      op = r[15:8];  // mostly invalid codes
    else
      op = 8'h80 >> r[2:0];
    a = {$random(seed), $random(seed)};
    b = {$random(seed), $random(seed)};
    case (r[17:16])
      2'd0: b = b >> r[23:18];  // small divisor, long quotient
      2'd1: a = a >> r[23:18];
      default: ;
    endcase
    send_job(op, a, b);
  endtask

  task automatic wait_all_done();
    @(negedge clk);
    while (exp_q.size() != 0 || result_ok_o || div_stall_o) @(negedge clk);
  endtask

  // ========================================
  // checker, samples on the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      in_hold        = 1'b0;
      result_ready_i = 1'b0;
    end else if (result_ok_o) begin
      if (!in_hold) begin
        in_hold = 1'b1;
        assert (div_stall_o === 1'b0) else begin
          $display("FAILED at %0t: div_stall_o expected 0 got %b (result_ok_o high)",
                   $time, div_stall_o);
          err_value++;
        end
        if (exp_q.size() == 0) begin
          $display("error at %0t: result_ok_o raised with no job outstanding", $time);
          err_other++;
        end else begin
          cur_exp = exp_q.pop_front();
          cur_op  = exp_op_q.pop_front();
          cur_a   = exp_a_q.pop_front();
          cur_b   = exp_b_q.pop_front();
          assert (result_o === cur_exp) else begin
            $display("FAILED at %0t: result_o expected %h got %h (op %b a %h b %h)",
                     $time, cur_exp, result_o, cur_op, cur_a, cur_b);
            err_value++;
          end
          jobs_checked++;
        end
        held_val = result_o;
        hold_rnd = $random(hold_seed);
        hold_cnt = hold_rnd[2:0];  // back-pressure length
      end else begin
        assert (result_o === held_val) else begin
          $display("FAILED at %0t: result_o expected %h got %h (changed while held)",
                   $time, held_val, result_o);
          err_value++;
        end
      end
      if (hold_cnt == 3'd0) begin
        result_ready_i = 1'b1;
      end else begin
        hold_cnt       = hold_cnt - 3'd1;
        result_ready_i = 1'b0;
      end
    end else begin
      in_hold        = 1'b0;
      result_ready_i = 1'b0;
      assert (result_o === 64'h0) else begin
        $display("FAILED at %0t: result_o expected %h got %h (result_ok_o low)",
                 $time, 64'h0, result_o);
        err_value++;
      end
    end
  end

  // ========================================
  // timeout
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish in %0d cycles, %0d of %0d jobs checked",
               TIMEOUT_CYCLES, jobs_checked, jobs_sent);
      $display("Some tests failed");
      $finish;
    end
  end

  // ========================================
  // main sequence
  initial begin
    rst_n       = 1'b1;   // active high
    div_valid_i = 1'b0;
    div_op_i    = '0;
    dividend_i  = '0;
    divisor_i   = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b0;
    @(negedge clk);
    assert (!div_stall_o && !result_ok_o) else begin
      $display("error at %0t: stall or result valid still high after reset", $time);
      err_other++;
    end

    // all ops on fixed pairs, negative operands and nonzero remainders
    send_all_ops(-64'sd100, 64'sd7);
    send_all_ops(64'sd100, -64'sd7);
    send_all_ops(64'hFEDC_BA98_7654_3210, 64'h0000_0000_1234_5678);
    send_all_ops(64'hDEAD_BEEF_8000_0123, 64'h1234_5678_FFFF_FFF9);  // word view -x / -7
    send_job(`DIV_OP_DIV, -64'sd1000, -64'sd33);
    send_job(`DIV_OP_REM, -64'sd1000, -64'sd33);

    // divide by zero, word divisor zero only in its low half
    send_all_ops(64'h0123_4567_89AB_CDEF, 64'h0);
    send_job(`DIV_OP_DIVW, 64'h0000_0000_0000_0055, 64'hFFFF_0000_0000_0000);
    send_job(`DIV_OP_REMUW, 64'h0000_0000_8000_0055, 64'hFFFF_0000_0000_0000);

    // signed overflow
    send_job(`DIV_OP_DIV, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF);
    send_job(`DIV_OP_REM, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF);
    send_job(`DIV_OP_DIVW, 64'h1234_5678_8000_0000, 64'h0000_0000_FFFF_FFFF);
    send_job(`DIV_OP_REMW, 64'h1234_5678_8000_0000, 64'h0000_0000_FFFF_FFFF);

    // invalid op codes
    send_job(8'h00, 64'd77, 64'd5);
    send_job(8'h81, 64'd77, 64'd5);

    // random jobs, results held back for random lengths
    repeat (N_RANDOM) send_random_job();

    wait_all_done();

    assert (jobs_checked == jobs_sent) else begin
      $display("error: %0d jobs sent but %0d results seen", jobs_sent, jobs_checked);
      err_other++;
    end
    $display("summary: %0d jobs checked, %0d value errors, %0d other errors",
             jobs_checked, err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+rtl
rtl/div_pkg.sv
rtl/div_if.sv
rtl/div_operand_prep.sv
rtl/div_restoring_core.sv
rtl/div_result_select.sv
rtl/div_unit.sv
tb/div_unit_tb.sv

/* Makefile */
# Verilator build and run of the divide unit testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module div_unit_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vdiv_unit_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
